// ==== all.f ====
src/soc_bus_pkg.sv
src/soc_periph_pkg.sv
src/wb_bus_ctrl.sv
src/main_ram.sv
src/uart_regs.sv
src/ipi_unit.sv
src/soc_fabric_top.sv
dv/soc_fabric_checker.sv
dv/soc_fabric_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the Wishbone fabric testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --timescale 1ns/10ps \
   --top-module soc_fabric_tb -f all.f -o soc_fabric_sim
./obj_dir/soc_fabric_sim | tee "$LOG"

if grep -q "All tests passed" "$LOG"; then
   exit 0
fi
exit 1

// ==== dv/soc_golden.txt ====
# op adr sel dat exp (hex). W write, R read and compare with exp, E write that ends in err,
# P read until all exp bits are set, I irq vectors with dat for core0 and exp for core1
I 00000000 0 00000000 00000000
W 00000000 f 11223344 00000000
R 00000000 f 00000000 11223344
W 00000004 f a5a5a5a5 00000000
W 00000004 3 0000beef 00000000
W 00000004 8 77000000 00000000
R 00000004 f 00000000 77a5beef
R 00000400 f 00000000 11223344
R 01fffc04 f 00000000 77a5beef
E 99000000 f deadbeef 00000000
E 40000000 f deadbeef 00000000
R 00000000 f 00000000 11223344
W 90000000 2 00000200 00000000
R 90000000 2 00000000 02020202
W 90000000 1 000000a5 00000000
R 90000004 2 00000000 00000000
P 90000004 2 00000000 00000020
R 90000000 1 00000000 a5a5a5a5
I 00000000 0 00000004 00000004
R 90000000 4 00000000 01010101
I 00000000 0 00000000 00000000
W 98000000 f 80011234 00000000
I 00000000 0 00000000 00000002
R 9800000c f 00000000 80001234
W 9800000c f 80000000 00000000
I 00000000 0 00000000 00000000
W 98000008 f 80005678 00000000
I 00000000 0 00000002 00000000
R 98000004 f 00000000 80005678
W 98000004 f 80000000 00000000
I 00000000 0 00000000 00000000
R 98000004 f 00000000 00005678

// ==== dv/soc_fabric_tb.sv ====
`timescale 1ns/10ps

module soc_fabric_tb;

   localparam int                RND_WORDS   = 16;
   localparam int                POLL_LIMIT  = 32;   // LSR reads before giving up
   localparam int                NS_PER_OP   = 600;
   localparam int                NS_PER_POLL = 100;
   localparam int                RSP_LIMIT   = 16;
   localparam soc_bus_pkg::adr_t RND_BASE    = 32'h0000_0100;
   localparam string             SCRIPT      = "dv/soc_golden.txt";

   logic                       wb_clk_i;
   logic                       reset_i;
   logic                       wb_cyc_i;
   logic                       wb_stb_i;
   logic                       wb_we_i;
   soc_bus_pkg::adr_t          wb_adr_i;
   soc_bus_pkg::sel_t          wb_sel_i;
   soc_bus_pkg::dat_t          wb_dat_i;
   soc_bus_pkg::dat_t          wb_dat_o;
   logic                       wb_ack_o;
   logic                       wb_err_o;
   logic                       uart_tx_o;
   soc_periph_pkg::irq_vec_t   core0_irq_o;
   soc_periph_pkg::irq_vec_t   core1_irq_o;

   int                         err_data;
   int                         err_irq;
   int                         err_resp;
   int                         err_other;
   logic                       loaded;
   logic                       load_ok;
   logic [7:0]                 op_q [$];   // Golden script, one entry per line
   soc_bus_pkg::adr_t          adr_q [$];
   soc_bus_pkg::sel_t          sel_q [$];
   soc_bus_pkg::dat_t          dat_q [$];
   soc_bus_pkg::dat_t          exp_q [$];
   soc_bus_pkg::dat_t          rnd_exp [RND_WORDS];
   soc_bus_pkg::dat_t          rdat;
   logic                       ack;
   logic                       err;

   soc_fabric_top soc_fabric_top_i (.*);

   always #10 wb_clk_i = ~wb_clk_i;

   //////////////////////////////
   // Compare tasks
   //////////////////////////////
   task automatic check_data(input soc_bus_pkg::dat_t got, input soc_bus_pkg::dat_t exp,
                             input string what);
      if (got !== exp) begin
         $display("ERROR %0t: %s read %h, expected %h", $time, what, got, exp);
         err_data++;
      end
   endtask

   task automatic check_irq(input soc_periph_pkg::irq_vec_t got,
                            input soc_periph_pkg::irq_vec_t exp, input string what);
      if (got !== exp) begin
         $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
         err_irq++;
      end
   endtask

   task automatic check_resp(input logic got_ack, input logic got_err, input logic exp_err,
                             input string what);
      if (got_ack !== !exp_err || got_err !== exp_err) begin
         $display("ERROR %0t: %s got ack %b err %b, expected %s", $time, what, got_ack,
                  got_err, exp_err ? "err" : "ack");
         err_resp++;
      end
   endtask

   task automatic check_idle(input string what);
      if (uart_tx_o !== 1'b1 || wb_ack_o !== 1'b0 || wb_err_o !== 1'b0) begin
         $display("ERROR %0t: %s tx %b ack %b err %b, expected idle", $time, what,
                  uart_tx_o, wb_ack_o, wb_err_o);
         err_other++;
      end
   endtask

   //////////////////////////////
   // Bus master
   //////////////////////////////
   task automatic bus_xfer(input logic we, input soc_bus_pkg::adr_t adr,
                           input soc_bus_pkg::sel_t sel, input soc_bus_pkg::dat_t dat,
                           output soc_bus_pkg::dat_t rd, output logic got_ack,
                           output logic got_err);
      int cycles;
      cycles = 0;
      @(negedge wb_clk_i);   // Previous stb low for a full cycle before this
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = adr;
      wb_sel_i = sel;
      wb_dat_i = dat;
      do begin
         @(negedge wb_clk_i);
         cycles++;
      end while (!(wb_ack_o || wb_err_o) && cycles < RSP_LIMIT);
      rd       = wb_dat_o;
      got_ack  = wb_ack_o;
      got_err  = wb_err_o;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      if (!(got_ack || got_err)) begin
         $display("No bus response within %0d cycles for address %h", RSP_LIMIT, adr);
         err_other++;
      end else if (cycles != 2) begin
         $display("ERROR %0t: response after %0d cycles, expected 2", $time, cycles);
         err_other++;
      end
   endtask

   task automatic load_script(output logic ok);
      int                fd;
      string             line;
      logic [7:0]        op;
      soc_bus_pkg::adr_t adr;
      soc_bus_pkg::sel_t sel;
      soc_bus_pkg::dat_t dat;
      soc_bus_pkg::dat_t exp;
      fd = $fopen(SCRIPT, "r");
      ok = (fd != 0);
      if (ok) begin
         while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) > 0 &&
                $sscanf(line, "%c %h %h %h %h", op, adr, sel, dat, exp) == 5) begin
               op_q.push_back(op);   // Comment and blank lines fall through
               adr_q.push_back(adr);
               sel_q.push_back(sel);
               dat_q.push_back(dat);
               exp_q.push_back(exp);
            end
         end
         $fclose(fd);
         ok = (op_q.size() > 0);
      end
   endtask

   task automatic run_op(input int n);
      soc_bus_pkg::dat_t rd;
      logic              got_ack;
      logic              got_err;
      int                polls;
      string             what;
      what = $sformatf("line %0d %s %h", n, op_q[n], adr_q[n]);
      case (op_q[n])
         "W": begin
            bus_xfer(1'b1, adr_q[n], sel_q[n], dat_q[n], rd, got_ack, got_err);
            check_resp(got_ack, got_err, 1'b0, what);
         end
         "E": begin
            bus_xfer(1'b1, adr_q[n], sel_q[n], dat_q[n], rd, got_ack, got_err);
            check_resp(got_ack, got_err, 1'b1, what);
         end
         "R": begin
            bus_xfer(1'b0, adr_q[n], sel_q[n], dat_q[n], rd, got_ack, got_err);
            check_resp(got_ack, got_err, 1'b0, what);
            check_data(rd, exp_q[n], what);
         end
         "P": begin
            polls = 0;
            do begin
               bus_xfer(1'b0, adr_q[n], sel_q[n], dat_q[n], rd, got_ack, got_err);
               check_resp(got_ack, got_err, 1'b0, what);
               polls++;
            end while ((rd & exp_q[n]) != exp_q[n] && polls < POLL_LIMIT);
            if ((rd & exp_q[n]) != exp_q[n]) begin
               $display("UART never reported transmitter empty in %0d status reads", polls);
               err_other++;
            end
            @(negedge wb_clk_i);   // Last status read back in idle
            check_idle("serial line after frame");
         end
         "I": begin
            @(negedge wb_clk_i);
            check_irq(core0_irq_o, dat_q[n], {what, " core0"});
            check_irq(core1_irq_o, exp_q[n], {what, " core1"});
         end
         default: begin
            $display("Unknown op in golden script at entry %0d", n);
            err_other++;
         end
      endcase
   endtask

   // Watchdog sized from the script length
   initial begin
      longint limit_ns;
      wait (loaded === 1'b1);
      limit_ns = longint'(op_q.size() + 2 * RND_WORDS) * NS_PER_OP + POLL_LIMIT * NS_PER_POLL;
      #(limit_ns);
      $display("Watchdog expired after %0d ns, the run did not finish", limit_ns);
      $display("Some tests failed");
      $finish;
   end

   //////////////////////////////
   // Main sequence
   //////////////////////////////
   initial begin
      void'($urandom(32'h7660));
      wb_clk_i  = 1'b0;
      reset_i   = 1'b1;
      wb_cyc_i  = 1'b0;
      wb_stb_i  = 1'b0;
      wb_we_i   = 1'b0;
      wb_adr_i  = '0;
      wb_sel_i  = '0;
      wb_dat_i  = '0;
      err_data  = 0;
      err_irq   = 0;
      err_resp  = 0;
      err_other = 0;
      loaded    = 1'b0;
      load_script(load_ok);
      if (!load_ok) begin
         $display("Could not read any transfers from %s", SCRIPT);
         $display("Some tests failed");
      end else begin
         loaded = 1'b1;
         repeat (3) @(negedge wb_clk_i);
         reset_i = 1'b0;
         check_idle("after reset");
         for (int n = 0; n < op_q.size(); n++)
            run_op(n);
         // Random RAM fill and readback
         for (int i = 0; i < RND_WORDS; i++) begin
            rnd_exp[i] = $urandom;
            bus_xfer(1'b1, RND_BASE + soc_bus_pkg::adr_t'(4 * i), 4'hf, rnd_exp[i], rdat,
                     ack, err);
            check_resp(ack, err, 1'b0, "random write");
         end
         for (int i = 0; i < RND_WORDS; i++) begin
            bus_xfer(1'b0, RND_BASE + soc_bus_pkg::adr_t'(4 * i), 4'hf, '0, rdat, ack, err);
            check_resp(ack, err, 1'b0, "random read");
            check_data(rdat, rnd_exp[i], $sformatf("random word %0d", i));
         end
         $display("Error counts: data %0d, irq %0d, response %0d, other %0d",
                  err_data, err_irq, err_resp, err_other);
         if (err_data + err_irq + err_resp + err_other == 0) begin
            $display("All tests passed");
         end else begin
            $display("Some tests failed");
         end
      end
      $finish;
   end

endmodule

// ==== dv/soc_fabric_checker.sv ====
`timescale 1ns/10ps

module soc_fabric_checker (
   input  logic                     wb_clk_i,
   input  logic                     reset_i,
   input  logic                     cyc_i,
   input  logic                     stb_i,
   input  logic                     ack_i,
   input  logic                     err_i,
   input  logic                     ram_stb_i,
   input  logic                     uart_stb_i,
   input  logic                     ipi_stb_i,
   input  soc_bus_pkg::bus_state_e  state_i
);

   logic any_stb;
   logic start;

   assign any_stb = ram_stb_i | uart_stb_i | ipi_stb_i;
   assign start   = (state_i == soc_bus_pkg::ST_IDLE) && cyc_i && stb_i;   // Accepted request

   //////////////////////////////
   // Handshake
   //////////////////////////////
   a_resp_excl: assert property (@(posedge wb_clk_i) disable iff (reset_i)
      !(ack_i && err_i)) else $error("ack and err high in the same cycle");

   a_no_early_resp: assert property (@(posedge wb_clk_i) disable iff (reset_i)
      start |=> !(ack_i || err_i)) else $error("response one cycle after request");

   a_resp_latency: assert property (@(posedge wb_clk_i) disable iff (reset_i)
      start |-> ##2 (ack_i || err_i)) else $error("no response two cycles after request");

   // Slave strobes
   a_one_stb: assert property (@(posedge wb_clk_i) disable iff (reset_i)
      $onehot0({ram_stb_i, uart_stb_i, ipi_stb_i})) else $error("more than one slave strobe");

   a_stb_in_access: assert property (@(posedge wb_clk_i) disable iff (reset_i)
      any_stb |-> (state_i == soc_bus_pkg::ST_ACCESS)) else $error("strobe outside access");

endmodule

bind wb_bus_ctrl soc_fabric_checker soc_fabric_checker_i (
   .wb_clk_i   (wb_clk_i),
   .reset_i    (reset_i),
   .cyc_i      (wb_cyc_i),
   .stb_i      (wb_stb_i),
   .ack_i      (wb_ack_o),
   .err_i      (wb_err_o),
   .ram_stb_i  (ram_stb_o),
   .uart_stb_i (uart_stb_o),
   .ipi_stb_i  (ipi_stb_o),
   .state_i    (state_q)
);

// ==== src/soc_fabric_top.sv ====
`timescale 1ns/10ps

module soc_fabric_top (
   input  logic                       wb_clk_i,
   input  logic                       reset_i,
   input  logic                       wb_cyc_i,
   input  logic                       wb_stb_i,
   input  logic                       wb_we_i,
   input  soc_bus_pkg::adr_t          wb_adr_i,
   input  soc_bus_pkg::sel_t          wb_sel_i,
   input  soc_bus_pkg::dat_t          wb_dat_i,
   output soc_bus_pkg::dat_t          wb_dat_o,
   output logic                       wb_ack_o,
   output logic                       wb_err_o,
   output logic                       uart_tx_o,
   output soc_periph_pkg::irq_vec_t   core0_irq_o,
   output soc_periph_pkg::irq_vec_t   core1_irq_o
);

   logic                                 slv_we;
   soc_bus_pkg::adr_t                    slv_adr;
   soc_bus_pkg::sel_t                    slv_sel;
   soc_bus_pkg::dat_t                    slv_dat;
   logic                                 ram_stb;
   logic                                 uart_stb;
   logic                                 ipi_stb;
   soc_bus_pkg::dat_t                    ram_dat;
   soc_bus_pkg::dat_t                    uart_dat;
   soc_bus_pkg::dat_t                    ipi_dat;
   logic                                 uart_irq;
   logic [soc_periph_pkg::NUM_CORES-1:0] ipi_irq;

   //////////////////////////////
   // Fabric and slaves
   //////////////////////////////
   wb_bus_ctrl wb_bus_ctrl_i (
      .wb_clk_i   (wb_clk_i),
      .reset_i    (reset_i),
      .wb_cyc_i   (wb_cyc_i),
      .wb_stb_i   (wb_stb_i),
      .wb_we_i    (wb_we_i),
      .wb_adr_i   (wb_adr_i),
      .wb_sel_i   (wb_sel_i),
      .wb_dat_i   (wb_dat_i),
      .wb_dat_o   (wb_dat_o),
      .wb_ack_o   (wb_ack_o),
      .wb_err_o   (wb_err_o),
      .slv_we_o   (slv_we),
      .slv_adr_o  (slv_adr),
      .slv_sel_o  (slv_sel),
      .slv_dat_o  (slv_dat),
      .ram_stb_o  (ram_stb),
      .uart_stb_o (uart_stb),
      .ipi_stb_o  (ipi_stb),
      .ram_dat_i  (ram_dat),
      .uart_dat_i (uart_dat),
      .ipi_dat_i  (ipi_dat)
   );

   main_ram main_ram_i (
      .wb_clk_i (wb_clk_i),
      .stb_i    (ram_stb),
      .we_i     (slv_we),
      .adr_i    (slv_adr),
      .sel_i    (slv_sel),
      .dat_i    (slv_dat),
      .dat_o    (ram_dat)
   );

   uart_regs uart_regs_i (
      .wb_clk_i   (wb_clk_i),
      .reset_i    (reset_i),
      .stb_i      (uart_stb),
      .we_i       (slv_we),
      .adr_i      (slv_adr),
      .sel_i      (slv_sel),
      .dat_i      (slv_dat),
      .dat_o      (uart_dat),
      .uart_tx_o  (uart_tx_o),
      .uart_irq_o (uart_irq)
   );

   ipi_unit ipi_unit_i (
      .wb_clk_i  (wb_clk_i),
      .reset_i   (reset_i),
      .stb_i     (ipi_stb),
      .we_i      (slv_we),
      .adr_i     (slv_adr),
      .dat_i     (slv_dat),
      .dat_o     (ipi_dat),
      .ipi_irq_o (ipi_irq)
   );

   //////////////////////////////
   // Interrupt vectors
   //////////////////////////////
   always_comb begin
      core0_irq_o = '0;
      core0_irq_o[soc_periph_pkg::IRQ_UART_BIT] = uart_irq;   // UART shared by both cores
      core0_irq_o[soc_periph_pkg::IRQ_IPI_BIT]  = ipi_irq[0];
      core1_irq_o = '0;
      core1_irq_o[soc_periph_pkg::IRQ_UART_BIT] = uart_irq;
      core1_irq_o[soc_periph_pkg::IRQ_IPI_BIT]  = ipi_irq[1];
   end

endmodule

// ==== src/ipi_unit.sv ====
`timescale 1ns/10ps

module ipi_unit (
   input  logic                                 wb_clk_i,
   input  logic                                 reset_i,
   input  logic                                 stb_i,
   input  logic                                 we_i,
   input  soc_bus_pkg::adr_t                    adr_i,
   input  soc_bus_pkg::dat_t                    dat_i,
   output soc_bus_pkg::dat_t                    dat_o,
   output logic [soc_periph_pkg::NUM_CORES-1:0] ipi_irq_o
);

   logic [soc_periph_pkg::IPI_CORE_W-1:0]    core_sel;
   logic [soc_periph_pkg::IPI_CORE_W-1:0]    target;
   logic [soc_periph_pkg::IPI_BLOCK_LSB-1:0] reg_ofs;
   logic                                     ctrl_wr;
   logic                                     ipi_set;
   logic                                     ipi_ack;
   logic [soc_periph_pkg::NUM_CORES-1:0]     pend_q;
   soc_bus_pkg::dat_t                        ctrl_q [soc_periph_pkg::NUM_CORES];
   logic [soc_periph_pkg::IPI_DATA_W-1:0]    data_q [soc_periph_pkg::NUM_CORES];
   soc_bus_pkg::dat_t                        stat_rd;

   assign core_sel = adr_i[soc_periph_pkg::IPI_BLOCK_LSB +: soc_periph_pkg::IPI_CORE_W];
   assign reg_ofs  = adr_i[soc_periph_pkg::IPI_BLOCK_LSB-1:0];
   assign target   = dat_i[soc_periph_pkg::IPI_TARGET_LSB +: soc_periph_pkg::IPI_CORE_W];

   assign ctrl_wr = stb_i && we_i && (reg_ofs == soc_periph_pkg::IPI_CTRL_OFS);
   assign ipi_set = ctrl_wr && dat_i[soc_periph_pkg::IPI_FLAG_BIT];
   assign ipi_ack = stb_i && we_i && (reg_ofs == soc_periph_pkg::IPI_STAT_OFS) &&
                    dat_i[soc_periph_pkg::IPI_FLAG_BIT];

   // Pending flags, one per core
   always_ff @(posedge wb_clk_i) begin
      if (reset_i) begin
         pend_q <= '0;
      end else begin
         if (ipi_set)
            pend_q[target] <= 1'b1;
         if (ipi_ack)
            pend_q[core_sel] <= 1'b0;   // Acknowledge by own core
      end
   end

   always_comb begin
      stat_rd = '0;
      stat_rd[soc_periph_pkg::IPI_FLAG_BIT] = pend_q[core_sel];
      stat_rd[soc_periph_pkg::IPI_DATA_W-1:0] = data_q[core_sel];
   end

   always_ff @(posedge wb_clk_i) begin
      if (ctrl_wr)
         ctrl_q[core_sel] <= dat_i;
      if (ipi_set)
         data_q[target] <= dat_i[soc_periph_pkg::IPI_DATA_W-1:0];   // Message for target
      if (stb_i && !we_i)
         dat_o <= (reg_ofs == soc_periph_pkg::IPI_STAT_OFS) ? stat_rd : ctrl_q[core_sel];
   end

   assign ipi_irq_o = pend_q;

endmodule

// ==== src/uart_regs.sv ====
`timescale 1ns/10ps

module uart_regs (
   input  logic                 wb_clk_i,
   input  logic                 reset_i,
   input  logic                 stb_i,
   input  logic                 we_i,
   input  soc_bus_pkg::adr_t    adr_i,
   input  soc_bus_pkg::sel_t    sel_i,
   input  soc_bus_pkg::dat_t    dat_i,
   output soc_bus_pkg::dat_t    dat_o,
   output logic                 uart_tx_o,
   output logic                 uart_irq_o
);

   logic [1:0]                             lane;
   logic [2:0]                             reg_ofs;
   logic [7:0]                             wr_byte;
   logic [7:0]                             rd_byte;
   logic [7:0]                             thr_q;
   logic [7:0]                             ier_q;
   logic                                   pend_q;
   logic [soc_periph_pkg::UART_FRAME_BITS-1:0] shift_q;
   logic [soc_periph_pkg::UART_CNT_W-1:0]  bit_cnt_q;
   logic [soc_periph_pkg::UART_DIV_W-1:0]  div_cnt_q;
   logic                                   busy;
   logic                                   bit_tick;
   logic                                   thr_wr;
   logic                                   ier_wr;
   logic                                   iir_rd;
   logic                                   tx_done;

   //////////////////////////////
   // 32 to 8 bit resize
   //////////////////////////////
   always_comb begin
      lane = 2'd0;
      for (int i = soc_bus_pkg::SEL_W-1; i >= 0; i--) begin
         if (sel_i[i])
            lane = 2'(i);   // Lowest enabled lane wins
      end
   end

   assign reg_ofs = {adr_i[2], lane};
   assign wr_byte = dat_i[8*lane +: 8];

   assign thr_wr = stb_i && we_i && (reg_ofs == soc_periph_pkg::UR_THR);
   assign ier_wr = stb_i && we_i && (reg_ofs == soc_periph_pkg::UR_IER);
   assign iir_rd = stb_i && !we_i && (reg_ofs == soc_periph_pkg::UR_IIR);

   always_comb begin
      rd_byte = 8'h00;
      case (soc_periph_pkg::uart_reg_e'(reg_ofs))
         soc_periph_pkg::UR_THR: rd_byte = thr_q;
         soc_periph_pkg::UR_IER: rd_byte = ier_q;
         soc_periph_pkg::UR_IIR: rd_byte[0] = pend_q;
         soc_periph_pkg::UR_LSR: rd_byte[soc_periph_pkg::UART_LSR_TEMT_BIT] = ~busy;
         default:                rd_byte = 8'h00;
      endcase
   end

   always_ff @(posedge wb_clk_i) begin
      if (thr_wr)
         thr_q <= wr_byte;
      if (stb_i && !we_i)
         dat_o <= {soc_bus_pkg::SEL_W{rd_byte}};   // Byte on every lane
   end

   //////////////////////////////
   // Transmit shifter
   //////////////////////////////
   assign busy     = (bit_cnt_q != '0);
   assign bit_tick = (div_cnt_q == soc_periph_pkg::UART_DIV_W'(soc_periph_pkg::UART_DIVISOR - 1));
   assign tx_done  = busy && bit_tick && (bit_cnt_q == 1) && !thr_wr;

   always_ff @(posedge wb_clk_i) begin
      if (reset_i) begin
         shift_q   <= '1;   // Line idles high
         bit_cnt_q <= '0;
         div_cnt_q <= '0;
         ier_q     <= '0;
         pend_q    <= 1'b0;
      end else begin
         if (thr_wr) begin
            shift_q   <= {1'b1, wr_byte, 1'b0};   // Stop, data LSB first, start
            bit_cnt_q <= soc_periph_pkg::UART_CNT_W'(soc_periph_pkg::UART_FRAME_BITS);
            div_cnt_q <= '0;
         end else if (busy) begin
            if (bit_tick) begin
               shift_q   <= {1'b1, shift_q[soc_periph_pkg::UART_FRAME_BITS-1:1]};
               bit_cnt_q <= bit_cnt_q - 1'b1;
               div_cnt_q <= '0;
            end else begin
               div_cnt_q <= div_cnt_q + 1'b1;
            end
         end
         if (ier_wr)
            ier_q <= wr_byte;
         if (tx_done)
            pend_q <= 1'b1;
         else if (thr_wr || iir_rd)
            pend_q <= 1'b0;   // Cleared by new data or IIR read
      end
   end

   assign uart_tx_o  = shift_q[0];
   assign uart_irq_o = pend_q & ier_q[soc_periph_pkg::UART_IER_TX_BIT];

endmodule

// ==== src/main_ram.sv ====
`timescale 1ns/10ps

module main_ram (
   input  logic                 wb_clk_i,
   input  logic                 stb_i,
   input  logic                 we_i,
   input  soc_bus_pkg::adr_t    adr_i,
   input  soc_bus_pkg::sel_t    sel_i,
   input  soc_bus_pkg::dat_t    dat_i,
   output soc_bus_pkg::dat_t    dat_o
);

   soc_bus_pkg::dat_t                      mem [2**soc_bus_pkg::RAM_ADR_BITS];
   logic [soc_bus_pkg::RAM_ADR_BITS-1:0]   word_idx;

   // Upper address bits alias onto the same words
   assign word_idx = adr_i[soc_bus_pkg::RAM_ADR_BITS+1:2];

   //////////////////////////////
   // Byte-select write
   //////////////////////////////
   always_ff @(posedge wb_clk_i) begin
      if (stb_i && we_i) begin
         for (int b = 0; b < soc_bus_pkg::SEL_W; b++) begin
            if (sel_i[b])
               mem[word_idx][8*b +: 8] <= dat_i[8*b +: 8];
         end
      end
   end

   // Registered read, ready the cycle after the strobe
   always_ff @(posedge wb_clk_i) begin
      if (stb_i && !we_i)
         dat_o <= mem[word_idx];
   end

endmodule

// ==== src/wb_bus_ctrl.sv ====
`timescale 1ns/10ps

module wb_bus_ctrl (
   input  logic                 wb_clk_i,
   input  logic                 reset_i,
   input  logic                 wb_cyc_i,
   input  logic                 wb_stb_i,
   input  logic                 wb_we_i,
   input  soc_bus_pkg::adr_t    wb_adr_i,
   input  soc_bus_pkg::sel_t    wb_sel_i,
   input  soc_bus_pkg::dat_t    wb_dat_i,
   output soc_bus_pkg::dat_t    wb_dat_o,
   output logic                 wb_ack_o,
   output logic                 wb_err_o,
   output logic                 slv_we_o,
   output soc_bus_pkg::adr_t    slv_adr_o,
   output soc_bus_pkg::sel_t    slv_sel_o,
   output soc_bus_pkg::dat_t    slv_dat_o,
   output logic                 ram_stb_o,
   output logic                 uart_stb_o,
   output logic                 ipi_stb_o,
   input  soc_bus_pkg::dat_t    ram_dat_i,
   input  soc_bus_pkg::dat_t    uart_dat_i,
   input  soc_bus_pkg::dat_t    ipi_dat_i
);

   soc_bus_pkg::bus_state_e state_q;
   soc_bus_pkg::slave_e     slv_q;
   soc_bus_pkg::slave_e     slv_dec;
   logic                    req;
   logic                    in_access;

   assign req = wb_cyc_i & wb_stb_i;

   //////////////////////////////
   // Address decode
   //////////////////////////////
   always_comb begin
      if (wb_adr_i[soc_bus_pkg::ADR_W-1 -: soc_bus_pkg::RAM_MATCH_W] == soc_bus_pkg::RAM_MATCH)
         slv_dec = soc_bus_pkg::SLV_RAM;
      else if (wb_adr_i[soc_bus_pkg::ADR_W-1 -: soc_bus_pkg::PERIPH_MATCH_W] ==
               soc_bus_pkg::UART_MATCH)
         slv_dec = soc_bus_pkg::SLV_UART;
      else if (wb_adr_i[soc_bus_pkg::ADR_W-1 -: soc_bus_pkg::PERIPH_MATCH_W] ==
               soc_bus_pkg::IPI_MATCH)
         slv_dec = soc_bus_pkg::SLV_IPI;
      else
         slv_dec = soc_bus_pkg::SLV_NONE;   // Unmapped, ends in err
   end

   //////////////////////////////
   // Sequencer
   //////////////////////////////
   always_ff @(posedge wb_clk_i) begin
      if (reset_i) begin
         state_q <= soc_bus_pkg::ST_IDLE;
         slv_q   <= soc_bus_pkg::SLV_NONE;
      end else begin
         case (state_q)
            soc_bus_pkg::ST_IDLE: begin
               if (req) begin
                  state_q <= soc_bus_pkg::ST_ACCESS;
                  slv_q   <= slv_dec;
               end
            end
            soc_bus_pkg::ST_ACCESS: state_q <= soc_bus_pkg::ST_RESP;   // Slave answers here
            default:                state_q <= soc_bus_pkg::ST_IDLE;
         endcase
      end
   end

   // Request held for the slave during the access
   always_ff @(posedge wb_clk_i) begin
      if (state_q == soc_bus_pkg::ST_IDLE && req) begin
         slv_we_o  <= wb_we_i;
         slv_adr_o <= wb_adr_i;
         slv_sel_o <= wb_sel_i;
         slv_dat_o <= wb_dat_i;
      end
   end

   assign in_access  = (state_q == soc_bus_pkg::ST_ACCESS);
   assign ram_stb_o  = in_access && (slv_q == soc_bus_pkg::SLV_RAM);
   assign uart_stb_o = in_access && (slv_q == soc_bus_pkg::SLV_UART);
   assign ipi_stb_o  = in_access && (slv_q == soc_bus_pkg::SLV_IPI);

   // Response phase
   assign wb_ack_o = (state_q == soc_bus_pkg::ST_RESP) && (slv_q != soc_bus_pkg::SLV_NONE);
   assign wb_err_o = (state_q == soc_bus_pkg::ST_RESP) && (slv_q == soc_bus_pkg::SLV_NONE);

   always_comb begin
      case (slv_q)
         soc_bus_pkg::SLV_RAM:  wb_dat_o = ram_dat_i;
         soc_bus_pkg::SLV_UART: wb_dat_o = uart_dat_i;
         soc_bus_pkg::SLV_IPI:  wb_dat_o = ipi_dat_i;
         default:               wb_dat_o = '0;
      endcase
   end

endmodule

// ==== src/soc_periph_pkg.sv ====
package soc_periph_pkg;

   localparam int NUM_CORES = 2;

   // Per-core interrupt vector layout
   typedef logic [31:0] irq_vec_t;
   localparam int IRQ_UART_BIT = 2;
   localparam int IRQ_IPI_BIT  = 1;

   //////////////////////////////
   // UART
   //////////////////////////////
   typedef enum logic [2:0] {
      UR_THR = 3'd0,   // Holding register, reads back last byte
      UR_IER = 3'd1,
      UR_IIR = 3'd2,
      UR_LSR = 3'd5
   } uart_reg_e;

   localparam int UART_IER_TX_BIT   = 1;   // Empty interrupt enable
   localparam int UART_LSR_TEMT_BIT = 5;   // Transmitter empty
   localparam int UART_DIVISOR      = 4;   // Clocks per serial bit
   localparam int UART_DIV_W        = $clog2(UART_DIVISOR);
   localparam int UART_FRAME_BITS   = 10;  // Start, 8 data, stop
   localparam int UART_CNT_W        = $clog2(UART_FRAME_BITS + 1);

   //////////////////////////////
   // IPI
   //////////////////////////////
   localparam logic [2:0] IPI_CTRL_OFS = 3'd0;
   localparam logic [2:0] IPI_STAT_OFS = 3'd4;
   localparam int IPI_BLOCK_LSB  = 3;   // 8-byte block per core
   localparam int IPI_CORE_W     = $clog2(NUM_CORES);
   localparam int IPI_FLAG_BIT   = 31;
   localparam int IPI_TARGET_LSB = 16;
   localparam int IPI_DATA_W     = 16;

endpackage

// ==== src/soc_bus_pkg.sv ====
package soc_bus_pkg;

   //////////////////////////////
   // Bus widths
   //////////////////////////////
   localparam int ADR_W = 32;
   localparam int DAT_W = 32;
   localparam int SEL_W = 4;

   typedef logic [ADR_W-1:0] adr_t;
   typedef logic [DAT_W-1:0] dat_t;
   typedef logic [SEL_W-1:0] sel_t;

   //////////////////////////////
   // Address map
   //////////////////////////////
   localparam int RAM_MATCH_W = 7;
   localparam logic [RAM_MATCH_W-1:0] RAM_MATCH = 7'h00;   // 0x0000_0000 .. 0x01ff_ffff

   localparam int PERIPH_MATCH_W = 16;
   localparam logic [PERIPH_MATCH_W-1:0] UART_MATCH = 16'h9000;
   localparam logic [PERIPH_MATCH_W-1:0] IPI_MATCH  = 16'h9800;

   localparam int RAM_ADR_BITS = 8;   // 256 words

   // Decoded target of a transfer
   typedef enum logic [1:0] {
      SLV_RAM,
      SLV_UART,
      SLV_IPI,
      SLV_NONE
   } slave_e;

   // Transfer sequencer
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ACCESS,
      ST_RESP
   } bus_state_e;

endpackage
